// File: source/alu.sv
`timescale 1ns/100ps
`include "processor_defs.svh"

module alu (
	input  logic                clk,
	input  logic                rst,
	input  datapathPkg::aluOpT  aluOp,
	input  logic                aluFlagWe,
	input  datapathPkg::wordT   a,
	input  datapathPkg::wordT   b,
	output datapathPkg::wordT   aluOut,
	output logic                cFlag,
	output logic                zFlag
);

	// Result with the carry or borrow in the top bit
	logic [`WORD_WIDTH:0] wideResult;
	logic carryOut;

	always_comb begin
		wideResult = '0;
		carryOut = 1'b0;
		case (aluOp)
			datapathPkg::aluAdd: begin
				wideResult = {1'b0, a} + {1'b0, b};
				carryOut = wideResult[`WORD_WIDTH];
			end
			datapathPkg::aluSub: begin
				// Top bit goes high on a borrow
				wideResult = {1'b0, a} - {1'b0, b};
				carryOut = wideResult[`WORD_WIDTH];
			end
			datapathPkg::aluAnd: wideResult = {1'b0, a & b};
			datapathPkg::aluOr:  wideResult = {1'b0, a | b};
			datapathPkg::aluXor: wideResult = {1'b0, a ^ b};
			datapathPkg::aluShl: begin
				wideResult = {1'b0, a[`WORD_WIDTH-2:0], 1'b0};
				carryOut = a[`WORD_WIDTH-1];
			end
			datapathPkg::aluShr: begin
				wideResult = {2'b00, a[`WORD_WIDTH-1:1]};
				carryOut = a[0];
			end
			default: begin
				// MOV passes rs through
				wideResult = {1'b0, b};
			end
		endcase
	end

	assign aluOut = wideResult[`WORD_WIDTH-1:0];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cFlag <= 1'b0;
			zFlag <= 1'b0;
		end else if (aluFlagWe) begin
			cFlag <= carryOut;
			zFlag <= (aluOut == '0);
		end
	end

endmodule

// File: source/dataMemory.sv
`timescale 1ns/100ps
`include "processor_defs.svh"

module dataMemory (
	input  logic                  clk,
	input  logic                  memWe,
	input  datapathPkg::wordT     rsData,
	input  isaPkg::imm8T          imm,
	input  datapathPkg::wordT     wData,
	output datapathPkg::wordT     rData,
	output datapathPkg::memAddrT  memWAddr
);

	datapathPkg::wordT mem [`MEM_DEPTH];

	// Base plus offset, wrapped to the memory size
	assign memWAddr = rsData[`MEM_ADDR_WIDTH-1:0] + datapathPkg::memAddrT'(imm);

	always_ff @(posedge clk) begin
		if (memWe) begin
			mem[memWAddr] <= wData;
		end
	end

	assign rData = mem[memWAddr];

endmodule

// File: source/datapathPkg.sv
`include "processor_defs.svh"

package datapathPkg;

	typedef logic [`WORD_WIDTH-1:0] wordT;

	// Low address bits shared by data memory and PC
	typedef logic [`MEM_ADDR_WIDTH-1:0] memAddrT;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluShl,
		aluShr,
		aluPass
	} aluOpT;

	// Register write-back source
	typedef enum logic [1:0] {
		wbAlu,
		wbImm,
		wbMem
	} wbSrcT;

	typedef enum logic [1:0] {
		pcNext,
		pcImm,
		pcReg
	} pcSelT;

	typedef enum logic [1:0] {
		stIdle,
		stRun,
		stHalt
	} runStateT;

endpackage

// File: source/decoder.sv
`timescale 1ns/100ps
`include "processor_defs.svh"

module decoder (
	input  isaPkg::instrT       instr,
	input  logic                cFlag,
	input  logic                zFlag,
	input  logic                en,
	output datapathPkg::aluOpT  aluOp,
	output logic                aluFlagWe,
	output logic                regWe,
	output isaPkg::regIdxT      rdIdx,
	output isaPkg::regIdxT      rsIdx,
	output datapathPkg::wbSrcT  wbSrc,
	output isaPkg::imm8T        imm,
	output logic                memWe,
	output datapathPkg::pcSelT  pcSel,
	output logic                halt
);

	isaPkg::opcodeT opcode;
	logic flagWeRaw;
	logic regWeRaw;
	logic memWeRaw;
	logic haltRaw;

	// Instruction fields
	assign opcode = isaPkg::opcodeT'(instr[`WORD_WIDTH-1 -: 4]);
	assign rdIdx = instr[11:10];
	assign rsIdx = instr[9:8];
	assign imm = instr[7:0];

	always_comb begin
		aluOp = datapathPkg::aluPass;
		flagWeRaw = 1'b0;
		regWeRaw = 1'b0;
		memWeRaw = 1'b0;
		haltRaw = 1'b0;
		wbSrc = datapathPkg::wbAlu;
		pcSel = datapathPkg::pcNext;
		case (opcode)
			isaPkg::opAdd: aluOp = datapathPkg::aluAdd;
			isaPkg::opSub: aluOp = datapathPkg::aluSub;
			isaPkg::opAnd: aluOp = datapathPkg::aluAnd;
			isaPkg::opOr:  aluOp = datapathPkg::aluOr;
			isaPkg::opXor: aluOp = datapathPkg::aluXor;
			isaPkg::opShl: aluOp = datapathPkg::aluShl;
			isaPkg::opShr: aluOp = datapathPkg::aluShr;
			default:       aluOp = datapathPkg::aluPass;
		endcase
		case (opcode)
			isaPkg::opAdd, isaPkg::opSub, isaPkg::opAnd, isaPkg::opOr,
			isaPkg::opXor, isaPkg::opShl, isaPkg::opShr: begin
				flagWeRaw = 1'b1;
				regWeRaw = 1'b1;
			end
			isaPkg::opMov: regWeRaw = 1'b1;
			isaPkg::opLdi: begin
				regWeRaw = 1'b1;
				wbSrc = datapathPkg::wbImm;
			end
			isaPkg::opLd: begin
				regWeRaw = 1'b1;
				wbSrc = datapathPkg::wbMem;
			end
			isaPkg::opSt:  memWeRaw = 1'b1;
			isaPkg::opJmp: pcSel = datapathPkg::pcImm;
			// Conditional jumps fall through when the flag is clear
			isaPkg::opJz:  pcSel = zFlag ? datapathPkg::pcImm : datapathPkg::pcNext;
			isaPkg::opJc:  pcSel = cFlag ? datapathPkg::pcImm : datapathPkg::pcNext;
			isaPkg::opJr:  pcSel = datapathPkg::pcReg;
			default:       haltRaw = 1'b1;
		endcase
	end

	// Strobes only act while the core runs
	assign aluFlagWe = en & flagWeRaw;
	assign regWe = en & regWeRaw;
	assign memWe = en & memWeRaw;
	assign halt = en & haltRaw;

endmodule

// File: source/fetchUnit.sv
`timescale 1ns/100ps
`include "processor_defs.svh"

module fetchUnit (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  loadEn,
	input  datapathPkg::memAddrT  loadAddr,
	input  isaPkg::instrT         loadData,
	input  logic                  start,
	input  datapathPkg::pcSelT    pcSel,
	input  isaPkg::imm8T          imm,
	input  datapathPkg::wordT     rsData,
	input  logic                  halt,
	output isaPkg::instrT         instr,
	output datapathPkg::memAddrT  pc,
	output logic                  running,
	output logic                  halted
);

	isaPkg::instrT instrMem [`MEM_DEPTH];
	datapathPkg::runStateT state;
	datapathPkg::memAddrT nextPc;

	// Program load is locked out while running
	always_ff @(posedge clk) begin
		if (loadEn && state != datapathPkg::stRun) begin
			instrMem[loadAddr] <= loadData;
		end
	end

	assign instr = instrMem[pc];

	always_comb begin
		case (pcSel)
			datapathPkg::pcImm: nextPc = datapathPkg::memAddrT'(imm);
			datapathPkg::pcReg: nextPc = rsData[`MEM_ADDR_WIDTH-1:0];
			default:            nextPc = pc + 1'b1;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= datapathPkg::stIdle;
			pc <= '0;
		end else begin
			case (state)
				datapathPkg::stRun: begin
					// PC stays on the HLT
					if (halt) begin
						state <= datapathPkg::stHalt;
					end else begin
						pc <= nextPc;
					end
				end
				default: begin
					if (start) begin
						state <= datapathPkg::stRun;
						pc <= '0;
					end
				end
			endcase
		end
	end

	assign running = (state == datapathPkg::stRun);
	assign halted = (state == datapathPkg::stHalt);

endmodule

// File: source/isaPkg.sv
`include "processor_defs.svh"

package isaPkg;

	// Opcode field, instruction bits 15:12
	typedef enum logic [3:0] {
		opAdd = 4'd0,
		opSub = 4'd1,
		opAnd = 4'd2,
		opOr  = 4'd3,
		opXor = 4'd4,
		opShl = 4'd5,
		opShr = 4'd6,
		opMov = 4'd7,
		opLdi = 4'd8,
		opLd  = 4'd9,
		opSt  = 4'd10,
		opJmp = 4'd11,
		opJz  = 4'd12,
		opJc  = 4'd13,
		opJr  = 4'd14,
		opHlt = 4'd15
	} opcodeT;

	// Register number, rd in 11:10 and rs in 9:8
	typedef logic [$clog2(`REG_COUNT)-1:0] regIdxT;

	// Immediate in 7:0, always zero-extended
	typedef logic [7:0] imm8T;

	typedef logic [`WORD_WIDTH-1:0] instrT;

endpackage

// File: source/processor.sv
`timescale 1ns/100ps
`include "processor_defs.svh"

module processor (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  loadEn,
	input  datapathPkg::memAddrT  loadAddr,
	input  isaPkg::instrT         loadData,
	input  logic                  start,
	output datapathPkg::memAddrT  pc,
	output logic                  halted,
	output logic [7:0]            led,
	output logic                  regWe,
	output isaPkg::regIdxT        regWIdx,
	output datapathPkg::wordT     regWData,
	output logic                  memWe,
	output datapathPkg::memAddrT  memWAddr,
	output datapathPkg::wordT     memWData
);

	isaPkg::instrT instr;
	isaPkg::regIdxT rsIdx;
	isaPkg::imm8T imm;
	datapathPkg::aluOpT aluOp;
	datapathPkg::wbSrcT wbSrc;
	datapathPkg::pcSelT pcSel;
	datapathPkg::wordT rdData;
	datapathPkg::wordT rsData;
	datapathPkg::wordT aluOut;
	datapathPkg::wordT memData;
	logic aluFlagWe;
	logic cFlag;
	logic zFlag;
	logic running;
	logic halt;

	fetchUnit fetchUnit_inst (
		.clk(clk),
		.rst(rst),
		.loadEn(loadEn),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.start(start),
		.pcSel(pcSel),
		.imm(imm),
		.rsData(rsData),
		.halt(halt),
		.instr(instr),
		.pc(pc),
		.running(running),
		.halted(halted)
	);

	decoder decoder_inst (
		.instr(instr),
		.cFlag(cFlag),
		.zFlag(zFlag),
		.en(running),
		.aluOp(aluOp),
		.aluFlagWe(aluFlagWe),
		.regWe(regWe),
		.rdIdx(regWIdx),
		.rsIdx(rsIdx),
		.wbSrc(wbSrc),
		.imm(imm),
		.memWe(memWe),
		.pcSel(pcSel),
		.halt(halt)
	);

	registerFile registerFile_inst (
		.clk(clk),
		.rst(rst),
		.regWe(regWe),
		.rdIdx(regWIdx),
		.rsIdx(rsIdx),
		.wbSrc(wbSrc),
		.aluOut(aluOut),
		.imm(imm),
		.memData(memData),
		.rdData(rdData),
		.rsData(rsData),
		.regWData(regWData)
	);

	alu alu_inst (
		.clk(clk),
		.rst(rst),
		.aluOp(aluOp),
		.aluFlagWe(aluFlagWe),
		.a(rdData),
		.b(rsData),
		.aluOut(aluOut),
		.cFlag(cFlag),
		.zFlag(zFlag)
	);

	// Store data comes from rd
	dataMemory dataMemory_inst (
		.clk(clk),
		.memWe(memWe),
		.rsData(rsData),
		.imm(imm),
		.wData(rdData),
		.rData(memData),
		.memWAddr(memWAddr)
	);

	assign memWData = rdData;
	assign led = pc[7:0];

endmodule

// File: source/processor_defs.svh
`ifndef PROCESSOR_DEFS_SVH
`define PROCESSOR_DEFS_SVH

// Data and instruction word width
`define WORD_WIDTH 16

// General registers in the register file
`define REG_COUNT 4

// Words in each of the two memories
`define MEM_DEPTH 512

// Address bits needed for MEM_DEPTH words
`define MEM_ADDR_WIDTH 9

`endif

// File: source/registerFile.sv
`timescale 1ns/100ps
`include "processor_defs.svh"

module registerFile (
	input  logic                clk,
	input  logic                rst,
	input  logic                regWe,
	input  isaPkg::regIdxT      rdIdx,
	input  isaPkg::regIdxT      rsIdx,
	input  datapathPkg::wbSrcT  wbSrc,
	input  datapathPkg::wordT   aluOut,
	input  isaPkg::imm8T        imm,
	input  datapathPkg::wordT   memData,
	output datapathPkg::wordT   rdData,
	output datapathPkg::wordT   rsData,
	output datapathPkg::wordT   regWData
);

	datapathPkg::wordT regs [`REG_COUNT];

	// Write-back select
	always_comb begin
		case (wbSrc)
			datapathPkg::wbImm: regWData = datapathPkg::wordT'(imm);
			datapathPkg::wbMem: regWData = memData;
			default:            regWData = aluOut;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (regWe) begin
			regs[rdIdx] <= regWData;
		end
	end

	assign rdData = regs[rdIdx];
	assign rsData = regs[rsIdx];

endmodule

// File: tests/processorTb.sv
`timescale 1ns/100ps
`include "processor_defs.svh"

module processorTb;

	logic clk = 1'b0;
	logic rst;
	logic loadEn;
	datapathPkg::memAddrT loadAddr;
	isaPkg::instrT loadData;
	logic start;
	datapathPkg::memAddrT pc;
	logic halted;
	logic [7:0] led;
	logic regWe;
	isaPkg::regIdxT regWIdx;
	datapathPkg::wordT regWData;
	logic memWe;
	datapathPkg::memAddrT memWAddr;
	datapathPkg::wordT memWData;

	int valueErrors = 0;
	int otherErrors = 0;

	// Program image as loaded, plus the reference model state
	isaPkg::instrT prog[$];
	isaPkg::instrT tbImem [`MEM_DEPTH];
	datapathPkg::wordT modelRegs [`REG_COUNT];
	datapathPkg::wordT modelMem [`MEM_DEPTH];
	logic modelC = 1'b0;
	logic modelZ = 1'b0;
	datapathPkg::memAddrT modelPc;

	// Expected writes in commit order
	isaPkg::regIdxT expRegIdx[$];
	datapathPkg::wordT expRegData[$];
	datapathPkg::memAddrT expMemAddr[$];
	datapathPkg::wordT expMemData[$];

	processor processor_inst (
		.clk(clk),
		.rst(rst),
		.loadEn(loadEn),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.start(start),
		.pc(pc),
		.halted(halted),
		.led(led),
		.regWe(regWe),
		.regWIdx(regWIdx),
		.regWData(regWData),
		.memWe(memWe),
		.memWAddr(memWAddr),
		.memWData(memWData)
	);

	always #4 clk = ~clk;

	// Whole run is a few hundred cycles
	initial begin
		#20000;
		$display("Timeout after 20000 ns, the run did not finish");
		$display("tests failed");
		$finish;
	end

	task automatic compareWord(datapathPkg::wordT got, datapathPkg::wordT exp, string name);
		if (got !== exp) begin
			$display("FAILED at %0t: %s expected %h, observed %h", $time, name, exp, got);
			valueErrors++;
		end
	endtask

	task automatic compareRegIdx(isaPkg::regIdxT got, isaPkg::regIdxT exp, string name);
		if (got !== exp) begin
			$display("FAILED at %0t: %s expected %0d, observed %0d", $time, name, exp, got);
			valueErrors++;
		end
	endtask

	task automatic compareAddr(datapathPkg::memAddrT got, datapathPkg::memAddrT exp,
			string name);
		if (got !== exp) begin
			$display("FAILED at %0t: %s expected %h, observed %h", $time, name, exp, got);
			valueErrors++;
		end
	endtask

	task automatic compareBit(logic got, logic exp, string name);
		if (got !== exp) begin
			$display("FAILED at %0t: %s expected %b, observed %b", $time, name, exp, got);
			valueErrors++;
		end
	endtask

	// Observation ports are stable mid-cycle
	always @(negedge clk) begin
		if (rst === 1'b0 && regWe === 1'b1) begin
			if (expRegIdx.size() == 0) begin
				$display("Unexpected register write to r%0d at %0t", regWIdx, $time);
				otherErrors++;
			end else begin
				compareRegIdx(regWIdx, expRegIdx.pop_front(), "regWIdx");
				compareWord(regWData, expRegData.pop_front(), "regWData");
			end
		end
		if (rst === 1'b0 && memWe === 1'b1) begin
			if (expMemAddr.size() == 0) begin
				$display("Unexpected memory write to %h at %0t", memWAddr, $time);
				otherErrors++;
			end else begin
				compareAddr(memWAddr, expMemAddr.pop_front(), "memWAddr");
				compareWord(memWData, expMemData.pop_front(), "memWData");
			end
		end
	end

	task automatic addInstr(isaPkg::opcodeT op, isaPkg::regIdxT rd, isaPkg::regIdxT rs,
			isaPkg::imm8T im);
		prog.push_back({op, rd, rs, im});
	endtask

	task automatic loadProgram();
		for (int i = 0; i < prog.size(); i++) begin
			@(posedge clk);
			#1;
			loadEn = 1'b1;
			loadAddr = datapathPkg::memAddrT'(i);
			loadData = prog[i];
			tbImem[i] = prog[i];
		end
		@(posedge clk);
		#1;
		loadEn = 1'b0;
	endtask

	task automatic modelRegWrite(isaPkg::regIdxT rd, datapathPkg::wordT value);
		modelRegs[rd] = value;
		expRegIdx.push_back(rd);
		expRegData.push_back(value);
	endtask

	// Executes the loaded image from address 0 by the ISA rules
	task automatic modelRun();
		isaPkg::instrT ins;
		isaPkg::opcodeT op;
		isaPkg::regIdxT rd;
		isaPkg::regIdxT rs;
		isaPkg::imm8T im;
		datapathPkg::wordT a;
		datapathPkg::wordT b;
		datapathPkg::wordT res;
		datapathPkg::memAddrT addr;
		logic carry;
		bit done;
		int steps;
		modelPc = '0;
		done = 1'b0;
		steps = 0;
		while (!done && steps < 1000) begin
			ins = tbImem[modelPc];
			op = isaPkg::opcodeT'(ins[15:12]);
			rd = ins[11:10];
			rs = ins[9:8];
			im = ins[7:0];
			a = modelRegs[rd];
			b = modelRegs[rs];
			addr = datapathPkg::memAddrT'(b + im);
			steps++;
			if (ins[15:12] < 4'd7) begin
				carry = 1'b0;
				case (op)
					isaPkg::opAdd: begin
						res = a + b;
						carry = (res < a);
					end
					isaPkg::opSub: begin
						res = a - b;
						carry = (a < b);
					end
					isaPkg::opAnd: res = a & b;
					isaPkg::opOr:  res = a | b;
					isaPkg::opXor: res = a ^ b;
					isaPkg::opShl: begin
						res = a << 1;
						carry = a[15];
					end
					default: begin
						res = a >> 1;
						carry = a[0];
					end
				endcase
				modelC = carry;
				modelZ = (res == 16'h0000);
				modelRegWrite(rd, res);
				modelPc++;
			end else begin
				case (op)
					isaPkg::opMov: modelRegWrite(rd, b);
					isaPkg::opLdi: modelRegWrite(rd, datapathPkg::wordT'(im));
					isaPkg::opLd:  modelRegWrite(rd, modelMem[addr]);
					isaPkg::opSt: begin
						modelMem[addr] = a;
						expMemAddr.push_back(addr);
						expMemData.push_back(a);
					end
					default: ;
				endcase
				case (op)
					isaPkg::opJmp: modelPc = im;
					isaPkg::opJz:  modelPc = modelZ ? im : modelPc + 1'b1;
					isaPkg::opJc:  modelPc = modelC ? im : modelPc + 1'b1;
					isaPkg::opJr:  modelPc = b[8:0];
					isaPkg::opHlt: done = 1'b1;
					default:       modelPc++;
				endcase
			end
		end
		if (!done) begin
			$display("Reference model did not reach HLT within 1000 steps");
			otherErrors++;
		end
	endtask

	task automatic startProgram();
		@(posedge clk);
		#1;
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
	endtask

	task automatic finishRun();
		int cycles;
		cycles = 0;
		while (halted !== 1'b1 && cycles < 1000) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (halted !== 1'b1) begin
			$display("Program did not halt within 1000 cycles at %0t", $time);
			otherErrors++;
		end
		repeat (3) @(posedge clk);
		#1;
		compareBit(halted, 1'b1, "halted");
		compareAddr(pc, modelPc, "pc");
		// LEDs show the low byte of the halt address
		compareWord(datapathPkg::wordT'(led), datapathPkg::wordT'(modelPc[7:0]), "led");
		if (expRegIdx.size() != 0 || expMemAddr.size() != 0) begin
			$display("Missing writes at halt: %0d register, %0d memory",
				expRegIdx.size(), expMemAddr.size());
			otherErrors++;
		end
		expRegIdx.delete();
		expRegData.delete();
		expMemAddr.delete();
		expMemData.delete();
	endtask

	task automatic runProgram();
		modelRun();
		startProgram();
		finishRun();
	endtask

	task automatic resetHaltTest();
		compareBit(halted, 1'b0, "halted");
		compareBit(regWe, 1'b0, "regWe");
		compareBit(memWe, 1'b0, "memWe");
		compareAddr(pc, '0, "pc");
		prog.delete();
		addInstr(isaPkg::opHlt, 0, 0, 0);
		loadProgram();
		runProgram();
		compareAddr(pc, '0, "pc");
		compareWord(datapathPkg::wordT'(led), '0, "led");
	endtask

	task automatic aluTest();
		prog.delete();
		for (int r = 0; r < `REG_COUNT; r++) begin
			addInstr(isaPkg::opLdi, r, 0, isaPkg::imm8T'($urandom()));
		end
		addInstr(isaPkg::opAdd, 0, 1, 0);
		addInstr(isaPkg::opSub, 1, 2, 0);
		addInstr(isaPkg::opJc, 0, 0, isaPkg::imm8T'(prog.size() + 2));
		addInstr(isaPkg::opLdi, 3, 0, 8'h11);
		addInstr(isaPkg::opAnd, 2, 0, 0);
		// AND clears C so this JC falls through
		addInstr(isaPkg::opJc, 0, 0, isaPkg::imm8T'(prog.size() + 2));
		addInstr(isaPkg::opOr, 3, 1, 0);
		addInstr(isaPkg::opXor, 0, 3, 0);
		addInstr(isaPkg::opShl, 1, 0, 0);
		addInstr(isaPkg::opShr, 2, 0, 0);
		addInstr(isaPkg::opMov, 3, 0, 0);
		addInstr(isaPkg::opSub, 3, 0, 0);
		addInstr(isaPkg::opJz, 0, 0, isaPkg::imm8T'(prog.size() + 2));
		addInstr(isaPkg::opLdi, 3, 0, 8'h22);
		// 0 - 1 borrows, then 0xffff + 1 carries
		addInstr(isaPkg::opLdi, 2, 0, 8'h01);
		addInstr(isaPkg::opSub, 3, 2, 0);
		addInstr(isaPkg::opJc, 0, 0, isaPkg::imm8T'(prog.size() + 2));
		addInstr(isaPkg::opLdi, 0, 0, 8'h33);
		addInstr(isaPkg::opAdd, 3, 2, 0);
		addInstr(isaPkg::opJc, 0, 0, isaPkg::imm8T'(prog.size() + 2));
		addInstr(isaPkg::opLdi, 1, 0, 8'h44);
		addInstr(isaPkg::opHlt, 0, 0, 0);
		loadProgram();
		runProgram();
	endtask

	task automatic memoryTest();
		isaPkg::imm8T off1;
		isaPkg::imm8T off3;
		off1 = isaPkg::imm8T'($urandom());
		off3 = isaPkg::imm8T'($urandom());
		prog.delete();
		addInstr(isaPkg::opLdi, 1, 0, isaPkg::imm8T'($urandom()));
		addInstr(isaPkg::opLdi, 0, 0, isaPkg::imm8T'($urandom()));
		addInstr(isaPkg::opSt, 0, 1, off1);
		addInstr(isaPkg::opLdi, 0, 0, isaPkg::imm8T'($urandom()));
		addInstr(isaPkg::opSt, 0, 1, off1 ^ 8'h80);
		// Base of 0x3fc wraps past the top of memory
		addInstr(isaPkg::opLdi, 2, 0, 8'hff);
		addInstr(isaPkg::opShl, 2, 0, 0);
		addInstr(isaPkg::opShl, 2, 0, 0);
		addInstr(isaPkg::opLdi, 0, 0, isaPkg::imm8T'($urandom()));
		addInstr(isaPkg::opShl, 0, 0, 0);
		addInstr(isaPkg::opSt, 0, 2, off3);
		addInstr(isaPkg::opLd, 3, 1, off1);
		addInstr(isaPkg::opLd, 0, 1, off1 ^ 8'h80);
		addInstr(isaPkg::opLd, 3, 2, off3);
		addInstr(isaPkg::opHlt, 0, 0, 0);
		loadProgram();
		runProgram();
	endtask

	task automatic controlFlowTest();
		prog.delete();
		addInstr(isaPkg::opLdi, 0, 0, 8'd5);
		addInstr(isaPkg::opLdi, 1, 0, 8'd1);
		addInstr(isaPkg::opLdi, 3, 0, 8'd10);
		// Countdown loop at 3
		addInstr(isaPkg::opSub, 0, 1, 0);
		addInstr(isaPkg::opJz, 0, 0, 8'd6);
		addInstr(isaPkg::opJmp, 0, 0, 8'd3);
		addInstr(isaPkg::opJmp, 0, 0, 8'd8);
		addInstr(isaPkg::opLdi, 2, 0, 8'hee);
		addInstr(isaPkg::opJr, 0, 3, 0);
		addInstr(isaPkg::opLdi, 2, 0, 8'hdd);
		addInstr(isaPkg::opLdi, 2, 0, 8'h5a);
		addInstr(isaPkg::opHlt, 0, 0, 0);
		loadProgram();
		runProgram();
		compareAddr(pc, 9'd11, "pc");
	endtask

	task automatic reloadTest();
		prog.delete();
		addInstr(isaPkg::opLdi, 1, 0, 8'd1);
		addInstr(isaPkg::opLdi, 0, 0, 8'd6);
		addInstr(isaPkg::opSub, 0, 1, 0);
		addInstr(isaPkg::opJz, 0, 0, 8'd5);
		addInstr(isaPkg::opJmp, 0, 0, 8'd2);
		addInstr(isaPkg::opLdi, 2, 0, 8'hab);
		addInstr(isaPkg::opHlt, 0, 0, 0);
		loadProgram();
		modelRun();
		startProgram();
		repeat (2) @(posedge clk);
		#1;
		compareBit(halted, 1'b0, "halted");
		// Must not replace the LDI at 5 while running
		loadEn = 1'b1;
		loadAddr = 9'd5;
		loadData = {isaPkg::opLdi, 2'd2, 2'd0, 8'h55};
		@(posedge clk);
		#1;
		loadEn = 1'b0;
		finishRun();
		prog.delete();
		addInstr(isaPkg::opMov, 3, 2, 0);
		addInstr(isaPkg::opAdd, 3, 0, 0);
		addInstr(isaPkg::opLdi, 1, 0, isaPkg::imm8T'($urandom()));
		addInstr(isaPkg::opHlt, 0, 0, 0);
		loadProgram();
		runProgram();
	endtask

	initial begin
		int seedValue;
		seedValue = $urandom(32'h6788c973);
		rst = 1'b1;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		start = 1'b0;
		for (int r = 0; r < `REG_COUNT; r++) begin
			modelRegs[r] = '0;
		end
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		resetHaltTest();
		aluTest();
		memoryTest();
		controlFlowTest();
		reloadTest();
		$display("Done: %0d value errors, %0d other errors", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: verilog.f
+incdir+source
source/isaPkg.sv
source/datapathPkg.sv
source/alu.sv
source/registerFile.sv
source/decoder.sv
source/fetchUnit.sv
source/dataMemory.sv
source/processor.sv
tests/processorTb.sv
